/* compile.f */
verilog/saturn_dbg_pkg.sv
verilog/dbg_char_buffer.sv
verilog/dbg_dump_formatter.sv
verilog/dbg_char_sender.sv
verilog/saturn_debugger.sv
verification/tb_saturn_debugger.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the debugger testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_saturn_debugger

# The log decides the result
./obj_dir/Vtb_saturn_debugger > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1

/* verification/tb_saturn_debugger.sv */
//********************
// Dump text and bus trace pairs are checked against models
// Bus events start after the first trigger with one pair in flight at a time
//********************
`default_nettype none

module tb_saturn_debugger;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_DUMPS = 4;
    localparam int WAIT_LIMIT = 4000;

    logic                      i_clk;
    logic                      i_reset;
    logic                      i_instr_decoded;
    logic                      i_exec_unit_busy;
    logic [19:0]               i_current_pc;
    logic                      i_reg_carry;
    logic [3:0]                i_reg_p;
    logic [15:0]               i_reg_st;
    saturn_dbg_pkg::reg_sel_t  o_dbg_register;
    logic [3:0]                o_dbg_reg_ptr;
    logic [3:0]                i_dbg_reg_nibble;
    logic                      i_bus_debug;
    logic [1:0]                i_bus_action;
    logic [3:0]                i_bus_data;
    logic                      i_serial_busy;
    saturn_dbg_pkg::dbg_char_t o_char_to_send;
    logic                      o_char_valid;
    logic                      o_char_send;
    logic                      o_debug_cycle;

    logic [63:0] reg_a;
    logic [63:0] reg_c;
    integer      seed;
    logic [7:0]  dump_q[$];
    logic [7:0]  bus_q[$];
    logic        prev_dc;
    logic        prev_valid;
    logic        prev_send;
    logic        prev_busy;
    logic        prev_trig;
    logic        prev_bus;
    logic        fall_due;
    logic        trig_seen;
    logic        stimulus_on;
    int          dumps_done;

    saturn_debugger #(
        .DUMP_DEPTH (128)
    ) dut_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_instr_decoded  (i_instr_decoded),
        .i_exec_unit_busy (i_exec_unit_busy),
        .i_current_pc     (i_current_pc),
        .i_reg_carry      (i_reg_carry),
        .i_reg_p          (i_reg_p),
        .i_reg_st         (i_reg_st),
        .o_dbg_register   (o_dbg_register),
        .o_dbg_reg_ptr    (o_dbg_reg_ptr),
        .i_dbg_reg_nibble (i_dbg_reg_nibble),
        .i_bus_debug      (i_bus_debug),
        .i_bus_action     (i_bus_action),
        .i_bus_data       (i_bus_data),
        .i_serial_busy    (i_serial_busy),
        .o_char_to_send   (o_char_to_send),
        .o_char_valid     (o_char_valid),
        .o_char_send      (o_char_send),
        .o_debug_cycle    (o_debug_cycle)
    );

    always #50 i_clk = ~i_clk;

    // Register file model answers the read port without a clock
    always_comb begin
        case (o_dbg_register)
            saturn_dbg_pkg::REG_A: i_dbg_reg_nibble = reg_a[o_dbg_reg_ptr*4 +: 4];
            saturn_dbg_pkg::REG_C: i_dbg_reg_nibble = reg_c[o_dbg_reg_ptr*4 +: 4];
            default:               i_dbg_reg_nibble = 4'h0;
        endcase
    end

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        if (nib > 4'd9) begin
            return "A" + {4'h0, nib - 4'd10};
        end
        return "0" + {4'h0, nib};
    endfunction

    function automatic logic [7:0] action_letter(input logic [1:0] action);
        case (action)
            2'd0:    return "w";
            2'd1:    return "c";
            2'd2:    return "r";
            default: return ".";
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic push_text(input string s);
        int i;
        for (i = 0; i < s.len(); i++) begin
            dump_q.push_back(s[i]);
        end
    endtask

    task automatic push_line_start();
        dump_q.push_back(8'h0a);
        dump_q.push_back(8'h0d);
    endtask

    // Text model of the dump for the values held at the trigger
    task automatic build_dump_model();
        int i;
        push_line_start();
        push_text("PC: ");
        for (i = 4; i >= 0; i--) begin
            dump_q.push_back(hex_ascii(i_current_pc[i*4 +: 4]));
        end
        push_text(" Carry: ");
        dump_q.push_back(i_reg_carry ? "1" : "0");
        push_text(" P: ");
        dump_q.push_back(hex_ascii(i_reg_p));
        push_line_start();
        push_text("ST: ");
        for (i = 15; i >= 0; i--) begin
            dump_q.push_back(i_reg_st[i] ? "1" : "0");
        end
        push_line_start();
        push_text("A: ");
        for (i = 15; i >= 0; i--) begin
            dump_q.push_back(hex_ascii(reg_a[i*4 +: 4]));
        end
        push_line_start();
        push_text("C: ");
        for (i = 15; i >= 0; i--) begin
            dump_q.push_back(hex_ascii(reg_c[i*4 +: 4]));
        end
        push_line_start();
    endtask

    task automatic drive_inputs();
        i_serial_busy   = ($random(seed) & 3) == 0;
        i_bus_debug     = 1'b0;
        i_instr_decoded = 1'b0;
        if (!i_reset && stimulus_on) begin
            i_instr_decoded  = ($random(seed) & 1) == 0;
            i_exec_unit_busy = ($random(seed) & 1) == 0;
        end
        // CPU state may only move outside a debug cycle
        if (!o_debug_cycle) begin
            i_current_pc = 20'($random(seed));
            i_reg_carry  = 1'($random(seed));
            i_reg_p      = 4'($random(seed));
            i_reg_st     = 16'($random(seed));
            reg_a        = {$random(seed), $random(seed)};
            reg_c        = {$random(seed), $random(seed)};
        end
        if (stimulus_on && trig_seen && bus_q.size() == 0 && ($random(seed) & 7) == 0) begin
            i_bus_debug  = 1'b1;
            i_bus_action = 2'($random(seed));
            i_bus_data   = 4'($random(seed));
        end
    endtask

    // Check what the last rising edge produced and drive the next inputs
    task automatic tick();
        logic [7:0] expect_char;
        logic       exp_dc;
        int         idx;
        @(negedge i_clk);
        exp_dc = prev_dc ? !fall_due : prev_trig;
        assert (o_debug_cycle === exp_dc) else report_error($sformatf(
            "MISMATCH at %0t: o_debug_cycle is %b, expected %b", $time, o_debug_cycle, exp_dc));
        fall_due = 1'b0;
        if (!prev_dc && o_debug_cycle) begin
            trig_seen = 1'b1;
            build_dump_model();
        end
        if (!o_debug_cycle) begin
            assert (o_dbg_register == saturn_dbg_pkg::REG_NONE)
                else report_error("Register select not idle outside a debug cycle");
        end
        if (!trig_seen) begin
            assert (!o_char_valid) else report_error("Character sent before any trigger");
        end
        if (o_char_valid) begin
            assert (!prev_valid) else report_error("o_char_valid high in two consecutive cycles");
            assert (!prev_busy) else report_error("Character sent while the serial port was busy");
            assert (o_char_send !== prev_send) else report_error("o_char_send did not toggle");
            if (bus_q.size() > 0) begin
                expect_char = bus_q.pop_front();
                assert (o_char_to_send === expect_char) else report_error($sformatf(
                    "MISMATCH at %0t: bus trace char 8'h%02h, expected 8'h%02h",
                    $time, o_char_to_send, expect_char));
            end else if (dump_q.size() > 0) begin
                idx         = saturn_dbg_pkg::DUMP_LEN - dump_q.size();
                expect_char = dump_q.pop_front();
                assert (o_char_to_send === expect_char) else report_error($sformatf(
                    "MISMATCH at %0t: dump char %0d is 8'h%02h, expected 8'h%02h",
                    $time, idx, o_char_to_send, expect_char));
                if (dump_q.size() == 0) begin
                    fall_due   = 1'b1;
                    dumps_done = dumps_done + 1;
                end
            end else begin
                report_error("Character sent when none was expected");
            end
        end else begin
            assert (o_char_send === prev_send) else report_error("o_char_send toggled with no char");
        end
        // Pair captured at the last edge follows any same-edge character
        if (prev_bus) begin
            bus_q.push_back(action_letter(i_bus_action));
            bus_q.push_back(hex_ascii(i_bus_data));
        end
        prev_dc    = o_debug_cycle;
        prev_valid = o_char_valid;
        prev_send  = o_char_send;
        drive_inputs();
        prev_busy = i_serial_busy;
        prev_trig = i_instr_decoded && !i_exec_unit_busy && !i_reset;
        prev_bus  = i_bus_debug;
    endtask

    initial begin
        int n;
        int wait_cycles;
        seed             = 32'ha777_991b;
        i_clk            = 1'b0;
        i_reset          = 1'b1;
        i_instr_decoded  = 1'b0;
        i_exec_unit_busy = 1'b0;
        i_current_pc     = '0;
        i_reg_carry      = 1'b0;
        i_reg_p          = '0;
        i_reg_st         = '0;
        i_bus_debug      = 1'b0;
        i_bus_action     = '0;
        i_bus_data       = '0;
        i_serial_busy    = 1'b0;
        reg_a            = '0;
        reg_c            = '0;
        prev_dc          = 1'b0;
        prev_valid       = 1'b0;
        prev_send        = 1'b0;
        prev_busy        = 1'b0;
        prev_trig        = 1'b0;
        prev_bus         = 1'b0;
        fall_due         = 1'b0;
        trig_seen        = 1'b0;
        stimulus_on      = 1'b1;
        dumps_done       = 0;

        repeat (8) tick();
        i_reset = 1'b0;

        for (n = 0; n < NUM_DUMPS; n++) begin
            wait_cycles = 0;
            while (dumps_done == n) begin
                tick();
                wait_cycles++;
                if (wait_cycles > WAIT_LIMIT) begin
                    report_error($sformatf("Timeout waiting for dump %0d to complete", n));
                end
            end
        end

        // Let the last dump end and the last bus pair drain
        stimulus_on = 1'b0;
        wait_cycles = 0;
        while (bus_q.size() > 0 || prev_bus || fall_due || o_debug_cycle) begin
            tick();
            wait_cycles++;
            if (wait_cycles > WAIT_LIMIT) begin
                report_error("Timeout waiting for the output to go idle");
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/saturn_debugger.sv */
//********************
// Register dump and bus trace over a serial character port
// PC, flags and register file must hold still while o_debug_cycle is high
//********************
`default_nettype none

module saturn_debugger #(
    parameter int DUMP_DEPTH = 128
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_reset,
    input  wire logic                      i_instr_decoded,
    input  wire logic                      i_exec_unit_busy,
    input  wire logic [19:0]               i_current_pc,
    input  wire logic                      i_reg_carry,
    input  wire logic [3:0]                i_reg_p,
    input  wire logic [15:0]               i_reg_st,
    output saturn_dbg_pkg::reg_sel_t       o_dbg_register,
    output logic [3:0]                     o_dbg_reg_ptr,
    input  wire logic [3:0]                i_dbg_reg_nibble,
    input  wire logic                      i_bus_debug,
    input  wire logic [1:0]                i_bus_action,
    input  wire logic [3:0]                i_bus_data,
    input  wire logic                      i_serial_busy,
    output saturn_dbg_pkg::dbg_char_t      o_char_to_send,
    output logic                           o_char_valid,
    output logic                           o_char_send,
    output logic                           o_debug_cycle
);

    localparam int AW = $clog2(DUMP_DEPTH);

    logic                      wr_en;
    logic [AW-1:0]             wr_addr;
    saturn_dbg_pkg::dbg_char_t wr_char;
    logic [AW-1:0]             rd_addr;
    saturn_dbg_pkg::dbg_char_t rd_char;
    logic                      dump_ready;
    logic                      dump_sent;

    dbg_dump_formatter #(
        .DUMP_DEPTH (DUMP_DEPTH)
    ) formatter_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_instr_decoded  (i_instr_decoded),
        .i_exec_unit_busy (i_exec_unit_busy),
        .i_current_pc     (i_current_pc),
        .i_reg_carry      (i_reg_carry),
        .i_reg_p          (i_reg_p),
        .i_reg_st         (i_reg_st),
        .i_dbg_reg_nibble (i_dbg_reg_nibble),
        .i_dump_sent      (dump_sent),
        .o_debug_cycle    (o_debug_cycle),
        .o_dbg_register   (o_dbg_register),
        .o_dbg_reg_ptr    (o_dbg_reg_ptr),
        .o_wr_en          (wr_en),
        .o_wr_addr        (wr_addr),
        .o_wr_char        (wr_char),
        .o_dump_ready     (dump_ready)
    );

    dbg_char_buffer #(
        .DUMP_DEPTH (DUMP_DEPTH)
    ) buffer_i (
        .i_clk     (i_clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_char (wr_char),
        .i_rd_addr (rd_addr),
        .o_rd_char (rd_char)
    );

    dbg_char_sender #(
        .DUMP_DEPTH (DUMP_DEPTH)
    ) sender_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_dump_ready   (dump_ready),
        .i_rd_char      (rd_char),
        .i_bus_debug    (i_bus_debug),
        .i_bus_action   (i_bus_action),
        .i_bus_data     (i_bus_data),
        .i_serial_busy  (i_serial_busy),
        .o_rd_addr      (rd_addr),
        .o_dump_sent    (dump_sent),
        .o_char_to_send (o_char_to_send),
        .o_char_valid   (o_char_valid),
        .o_char_send    (o_char_send)
    );

endmodule

`default_nettype wire

/* verilog/dbg_char_sender.sv */
//********************
// Sends one character per free slot
// Bus trace pairs go before dump text
// A new bus event must wait until both characters of the last pair are out
//********************
`default_nettype none

module dbg_char_sender #(
    parameter int DUMP_DEPTH = 128
) (
    input  wire logic                          i_clk,
    input  wire logic                          i_reset,
    input  wire logic                          i_dump_ready,
    input  wire saturn_dbg_pkg::dbg_char_t     i_rd_char,
    input  wire logic                          i_bus_debug,
    input  wire logic [1:0]                    i_bus_action,
    input  wire logic [3:0]                    i_bus_data,
    input  wire logic                          i_serial_busy,
    output logic [$clog2(DUMP_DEPTH)-1:0]      o_rd_addr,
    output logic                               o_dump_sent,
    output saturn_dbg_pkg::dbg_char_t          o_char_to_send,
    output logic                               o_char_valid,
    output logic                               o_char_send
);

    localparam int AW = $clog2(DUMP_DEPTH);

    logic          bus_pending;
    logic          bus_second;
    logic [1:0]    bus_action_q;
    logic [3:0]    bus_nibble_q;
    logic          dump_active;
    logic          pf_valid;
    logic [AW-1:0] rd_ptr;
    logic          slot_free;

    assign slot_free = !o_char_valid && !i_serial_busy;
    assign o_rd_addr = rd_ptr;

    always_ff @(posedge i_clk) begin
        o_char_valid <= 1'b0;
        o_dump_sent  <= 1'b0;
        if (i_reset) begin
            o_char_send <= 1'b0;
            bus_pending <= 1'b0;
            bus_second  <= 1'b0;
            dump_active <= 1'b0;
            pf_valid    <= 1'b0;
            rd_ptr      <= '0;
        end else begin
            // Buffer output is valid one clock after the pointer settles
            if (dump_active && !pf_valid) begin
                pf_valid <= 1'b1;
            end
            if (i_dump_ready) begin
                dump_active <= 1'b1;
                pf_valid    <= 1'b0;
                rd_ptr      <= '0;
            end

            if (slot_free && bus_pending) begin
                o_char_valid <= 1'b1;
                o_char_send  <= ~o_char_send;
                if (bus_second) begin
                    o_char_to_send <= saturn_dbg_pkg::hex_char(bus_nibble_q);
                    bus_pending    <= 1'b0;
                end else begin
                    o_char_to_send <= saturn_dbg_pkg::bus_action_char(bus_action_q);
                    bus_second     <= 1'b1;
                end
            end else if (slot_free && dump_active && pf_valid) begin
                o_char_valid   <= 1'b1;
                o_char_send    <= ~o_char_send;
                o_char_to_send <= i_rd_char;
                rd_ptr         <= rd_ptr + AW'(1);
                pf_valid       <= 1'b0;
                if (rd_ptr == AW'(saturn_dbg_pkg::DUMP_LEN - 1)) begin
                    dump_active <= 1'b0;
                    o_dump_sent <= 1'b1;
                end
            end

            // Capture after the slot so a same-edge emission keeps the old schedule
            if (i_bus_debug) begin
                bus_pending <= 1'b1;
                bus_second  <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_bus_debug) begin
            bus_action_q <= i_bus_action;
            bus_nibble_q <= i_bus_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/dbg_dump_formatter.sv */
//********************
// Writes the 91 character dump, one character per clock
// Register read port is answered combinationally and sampled the same cycle
//********************
`default_nettype none

module dbg_dump_formatter #(
    parameter int DUMP_DEPTH = 128
) (
    input  wire logic                       i_clk,
    input  wire logic                       i_reset,
    input  wire logic                       i_instr_decoded,
    input  wire logic                       i_exec_unit_busy,
    input  wire logic [19:0]                i_current_pc,
    input  wire logic                       i_reg_carry,
    input  wire logic [3:0]                 i_reg_p,
    input  wire logic [15:0]                i_reg_st,
    input  wire logic [3:0]                 i_dbg_reg_nibble,
    input  wire logic                       i_dump_sent,
    output logic                            o_debug_cycle,
    output saturn_dbg_pkg::reg_sel_t        o_dbg_register,
    output logic [3:0]                      o_dbg_reg_ptr,
    output logic                            o_wr_en,
    output logic [$clog2(DUMP_DEPTH)-1:0]   o_wr_addr,
    output saturn_dbg_pkg::dbg_char_t       o_wr_char,
    output logic                            o_dump_ready
);

    localparam int AW = $clog2(DUMP_DEPTH);

    saturn_dbg_pkg::dump_step_t step;
    logic [3:0]                 fld_ptr;
    logic [3:0]                 fld_last;
    logic [AW-1:0]              wr_addr;
    logic [2:0]                 pc_sel;
    logic                       fld_end;
    saturn_dbg_pkg::dbg_char_t  wr_char;

    // PC goes out most significant nibble first
    assign pc_sel  = 3'd4 - fld_ptr[2:0];
    assign fld_end = (fld_ptr == fld_last);

    always_comb begin
        wr_char  = " ";
        fld_last = 4'd0;
        case (step)
            saturn_dbg_pkg::PC_LABEL: begin
                fld_last = 4'd5;
                case (fld_ptr)
                    4'd2:    wr_char = "P";
                    4'd3:    wr_char = "C";
                    4'd4:    wr_char = ":";
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::PC_HEX: begin
                fld_last = 4'd4;
                wr_char  = saturn_dbg_pkg::hex_char(i_current_pc[pc_sel*4 +: 4]);
            end
            saturn_dbg_pkg::CARRY: begin
                fld_last = 4'd8;
                case (fld_ptr)
                    4'd1:    wr_char = "C";
                    4'd2:    wr_char = "a";
                    4'd3:    wr_char = "r";
                    4'd4:    wr_char = "r";
                    4'd5:    wr_char = "y";
                    4'd6:    wr_char = ":";
                    4'd8:    wr_char = saturn_dbg_pkg::hex_char({3'b000, i_reg_carry});
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::P_FIELD: begin
                fld_last = 4'd4;
                case (fld_ptr)
                    4'd1:    wr_char = "P";
                    4'd2:    wr_char = ":";
                    4'd4:    wr_char = saturn_dbg_pkg::hex_char(i_reg_p);
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::ST_LABEL: begin
                fld_last = 4'd5;
                case (fld_ptr)
                    4'd2:    wr_char = "S";
                    4'd3:    wr_char = "T";
                    4'd4:    wr_char = ":";
                    default: wr_char = " ";
                endcase
            end
            saturn_dbg_pkg::ST_BITS: begin
                fld_last = 4'd15;
                wr_char  = saturn_dbg_pkg::hex_char({3'b000, i_reg_st[4'd15 - fld_ptr]});
            end
            saturn_dbg_pkg::A_LABEL, saturn_dbg_pkg::C_LABEL: begin
                fld_last = 4'd4;
                if (fld_ptr == 4'd2) begin
                    wr_char = (step == saturn_dbg_pkg::A_LABEL) ? "A" : "C";
                end else if (fld_ptr == 4'd3) begin
                    wr_char = ":";
                end
            end
            saturn_dbg_pkg::A_HEX, saturn_dbg_pkg::C_HEX: begin
                fld_last = 4'd15;
                wr_char  = saturn_dbg_pkg::hex_char(i_dbg_reg_nibble);
            end
            saturn_dbg_pkg::TAIL: fld_last = 4'd1;
            default: fld_last = 4'd0;
        endcase

        // Every line opens with LF CR
        if (fld_ptr < 4'd2 && (step == saturn_dbg_pkg::PC_LABEL ||
                               step == saturn_dbg_pkg::ST_LABEL ||
                               step == saturn_dbg_pkg::A_LABEL  ||
                               step == saturn_dbg_pkg::C_LABEL  ||
                               step == saturn_dbg_pkg::TAIL)) begin
            wr_char = fld_ptr[0] ? saturn_dbg_pkg::CHAR_CR : saturn_dbg_pkg::CHAR_LF;
        end
    end

    assign o_wr_en   = o_debug_cycle && (step != saturn_dbg_pkg::DONE);
    assign o_wr_addr = wr_addr;
    assign o_wr_char = wr_char;

    always_ff @(posedge i_clk) begin
        o_dump_ready <= 1'b0;
        if (i_reset) begin
            o_debug_cycle  <= 1'b0;
            o_dbg_register <= saturn_dbg_pkg::REG_NONE;
            o_dbg_reg_ptr  <= 4'd0;
            step           <= saturn_dbg_pkg::DONE;
            fld_ptr        <= 4'd0;
            wr_addr        <= '0;
        end else if (!o_debug_cycle) begin
            if (i_instr_decoded && !i_exec_unit_busy) begin
                o_debug_cycle <= 1'b1;
                step          <= saturn_dbg_pkg::PC_LABEL;
                fld_ptr       <= 4'd0;
                wr_addr       <= '0;
            end
        end else if (step == saturn_dbg_pkg::DONE) begin
            // Hold the cycle until the sender has emitted the last character
            if (i_dump_sent) begin
                o_debug_cycle <= 1'b0;
            end
        end else begin
            wr_addr <= wr_addr + AW'(1);
            if (fld_end) begin
                fld_ptr <= 4'd0;
                step    <= saturn_dbg_pkg::dump_step_t'(step + 4'd1);
            end else begin
                fld_ptr <= fld_ptr + 4'd1;
            end
            if (step == saturn_dbg_pkg::TAIL && fld_end) begin
                o_dump_ready <= 1'b1;
            end

            // Select the register one write ahead of its first nibble
            if (fld_end && step == saturn_dbg_pkg::A_LABEL) begin
                o_dbg_register <= saturn_dbg_pkg::REG_A;
                o_dbg_reg_ptr  <= 4'd15;
            end
            if (fld_end && step == saturn_dbg_pkg::C_LABEL) begin
                o_dbg_register <= saturn_dbg_pkg::REG_C;
                o_dbg_reg_ptr  <= 4'd15;
            end
            if (step == saturn_dbg_pkg::A_HEX || step == saturn_dbg_pkg::C_HEX) begin
                o_dbg_reg_ptr <= o_dbg_reg_ptr - 4'd1;
                if (fld_end) begin
                    o_dbg_register <= saturn_dbg_pkg::REG_NONE;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/dbg_char_buffer.sv */
//********************
// Read data arrives one clock after the address
//********************
`default_nettype none

module dbg_char_buffer #(
    parameter int DUMP_DEPTH = 128
) (
    input  wire logic                          i_clk,
    input  wire logic                          i_wr_en,
    input  wire logic [$clog2(DUMP_DEPTH)-1:0] i_wr_addr,
    input  wire saturn_dbg_pkg::dbg_char_t     i_wr_char,
    input  wire logic [$clog2(DUMP_DEPTH)-1:0] i_rd_addr,
    output saturn_dbg_pkg::dbg_char_t          o_rd_char
);

    saturn_dbg_pkg::dbg_char_t mem [DUMP_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_char;
        end
        o_rd_char <= mem[i_rd_addr];
    end

endmodule

`default_nettype wire

/* verilog/saturn_dbg_pkg.sv */
//********************
// Dump layout constants and ASCII helpers shared by the debugger blocks
// Hex digits are upper case
// Bus action codes run from 0 to 3
//********************
`default_nettype none

package saturn_dbg_pkg;

    // Length of the fixed dump text
    localparam int DUMP_LEN = 91;

    typedef logic [7:0] dbg_char_t;

    localparam dbg_char_t CHAR_LF = 8'h0a;
    localparam dbg_char_t CHAR_CR = 8'h0d;

    typedef enum logic [1:0] {
        REG_NONE = 2'd0,
        REG_A    = 2'd1,
        REG_C    = 2'd2
    } reg_sel_t;

    typedef enum logic [3:0] {
        PC_LABEL, PC_HEX, CARRY, P_FIELD, ST_LABEL, ST_BITS,
        A_LABEL, A_HEX, C_LABEL, C_HEX, TAIL, DONE
    } dump_step_t;

    function automatic dbg_char_t hex_char(input logic [3:0] nib);
        // ASCII '0' is 0x30 and 'A' minus 10 is 0x37
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    function automatic dbg_char_t bus_action_char(input logic [1:0] action);
        case (action)
            2'd0:    return "w";
            2'd1:    return "c";
            2'd2:    return "r";
            default: return ".";
        endcase
    endfunction

endpackage

`default_nettype wire
